// File: logic/issue_lane_register.sv
module issue_lane_register (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush_i,
    input  logic                        load_i,
    input  logic                        accept_i,
    input  issue_pkg::dispatch_packet_t packet_i,
    output logic                        valid_o,
    output issue_pkg::dispatch_packet_t packet_o
);

    import issue_pkg::*;

    logic             valid_q;
    dispatch_packet_t packet_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q  <= 1'b0;
            packet_q <= '0;
        end else if (flush_i) begin
            valid_q  <= 1'b0;       // Bubble
            packet_q <= '0;
        end else begin
            valid_q <= accept_i;    // Drops under back-pressure
            if (load_i) begin
                packet_q <= packet_i;
            end
        end
    end

    assign valid_o  = valid_q && !flush_i;
    assign packet_o = packet_q;

    // A lane can only be granted while dispatch takes its slot
    assert property (@(posedge clk) disable iff (!reset) accept_i |-> load_i)
        else $error("lane accepted without dispatch ready");

endmodule

// File: logic/issue_pkg.sv
package issue_pkg;

    // ====================
    // Lane count and widths
    // ====================
    localparam int ISSUE_WIDTH = 3;
    localparam int XLEN        = 32;
    localparam int ARCH_REGS   = 32;
    localparam int ARCH_ADDR_W = 5;
    localparam int PHYS_REGS   = 64;
    localparam int PHYS_ADDR_W = 6;
    localparam int FREE_DEPTH  = 32;    // PHYS_REGS - ARCH_REGS
    localparam int FREE_CNT_W  = 6;     // Holds 0 to FREE_DEPTH
    localparam int FREE_PTR_W  = 5;     // Index into the free queue

    // ====================
    // RV32I major opcodes
    // ====================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef logic [ARCH_ADDR_W-1:0] arch_addr_t;
    typedef logic [PHYS_ADDR_W-1:0] phys_addr_t;

    // One instruction as it comes from fetch
    typedef struct packed {
        logic [XLEN-1:0] instruction;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_at_prediction;
        logic [XLEN-1:0] immediate;
        logic            branch_prediction;
    } fetch_packet_t;

    typedef struct packed {
        arch_addr_t rs1;
        arch_addr_t rs2;
        arch_addr_t rd;
        logic       writes_rd;
        logic       is_mem;
        logic       is_branch;
        logic       is_jalr;
    } decode_info_t;

    // Renamed instruction handed to dispatch
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_at_prediction;
        logic [XLEN-1:0] immediate;
        logic            branch_prediction;
        phys_addr_t      rs1_phys;
        phys_addr_t      rs2_phys;
        phys_addr_t      rd_phys;
        arch_addr_t      rd_arch;
        logic            writes_rd;
        logic            is_mem;
        logic            is_branch;
        logic            is_jalr;
    } dispatch_packet_t;

endpackage

// File: logic/issue_slot_arbiter.sv
module issue_slot_arbiter (
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] dispatch_ready_i,
    input  logic                              flush_i,
    input  logic [issue_pkg::FREE_CNT_W-1:0]  free_count_i,
    output logic [issue_pkg::ISSUE_WIDTH-1:0] decode_ready_o
);

    import issue_pkg::*;

    logic [1:0] grants;

    // Lane 0 has priority, stop when free registers run out
    always_comb begin
        grants         = 2'd0;
        decode_ready_o = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (!flush_i && dispatch_ready_i[k] && (FREE_CNT_W'(grants) < free_count_i)) begin
                decode_ready_o[k] = 1'b1;
                grants            = grants + 2'd1;
            end
        end
    end

    always_comb begin
        assert final (FREE_CNT_W'($countones(decode_ready_o)) <= free_count_i)
            else $error("granted %0d lanes with %0d free", $countones(decode_ready_o),
                        free_count_i);
    end

endmodule

// File: logic/issue_stage.sv
module issue_stage (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0]                         fetch_valid_i,
    input  issue_pkg::fetch_packet_t [issue_pkg::ISSUE_WIDTH-1:0]     fetch_i,
    output logic [issue_pkg::ISSUE_WIDTH-1:0]                         decode_ready_o,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0]                         dispatch_ready_i,
    output logic [issue_pkg::ISSUE_WIDTH-1:0]                         dispatch_valid_o,
    output issue_pkg::dispatch_packet_t [issue_pkg::ISSUE_WIDTH-1:0]  dispatch_o,
    input  logic                                                      flush_i,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0]                         commit_valid_i,
    input  issue_pkg::phys_addr_t [issue_pkg::ISSUE_WIDTH-1:0]        commit_phys_i
);

    import issue_pkg::*;

    decode_info_t [ISSUE_WIDTH-1:0]     info;
    phys_addr_t [ISSUE_WIDTH-1:0]       head_phys;
    phys_addr_t [ISSUE_WIDTH-1:0]       rs1_phys;
    phys_addr_t [ISSUE_WIDTH-1:0]       rs2_phys;
    phys_addr_t [ISSUE_WIDTH-1:0]       rd_phys;
    dispatch_packet_t [ISSUE_WIDTH-1:0] lane_packet;
    logic [ISSUE_WIDTH-1:0]             accept;
    logic [FREE_CNT_W-1:0]              free_count;
    logic [1:0]                         pop_count;

    assign accept = fetch_valid_i & decode_ready_o;

    // ====================
    // Decode and arbitration
    // ====================
    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_decode
        rv32i_field_decoder u_decoder (
            .instruction_i (fetch_i[k].instruction),
            .info_o        (info[k])
        );
    end

    issue_slot_arbiter u_arbiter (
        .dispatch_ready_i (dispatch_ready_i),
        .flush_i          (flush_i),
        .free_count_i     (free_count),
        .decode_ready_o   (decode_ready_o)
    );

    // ====================
    // Renaming
    // ====================
    rename_table u_rename (
        .clk         (clk),
        .reset       (reset),
        .accept_i    (accept),
        .info_i      (info),
        .head_phys_i (head_phys),
        .rs1_phys_o  (rs1_phys),
        .rs2_phys_o  (rs2_phys),
        .rd_phys_o   (rd_phys),
        .pop_count_o (pop_count)
    );

    phys_free_list u_free_list (
        .clk          (clk),
        .reset        (reset),
        .pop_count_i  (pop_count),
        .push_valid_i (commit_valid_i),     // Registers freed at commit
        .push_phys_i  (commit_phys_i),
        .head_phys_o  (head_phys),
        .free_count_o (free_count)
    );

    // Assemble what dispatch sees
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            lane_packet[k].pc                = fetch_i[k].pc;
            lane_packet[k].pc_at_prediction  = fetch_i[k].pc_at_prediction;
            lane_packet[k].immediate         = fetch_i[k].immediate;
            lane_packet[k].branch_prediction = fetch_i[k].branch_prediction;
            lane_packet[k].rs1_phys          = rs1_phys[k];
            lane_packet[k].rs2_phys          = rs2_phys[k];
            lane_packet[k].rd_phys           = rd_phys[k];
            lane_packet[k].rd_arch           = info[k].rd;
            lane_packet[k].writes_rd         = info[k].writes_rd;
            lane_packet[k].is_mem            = info[k].is_mem;
            lane_packet[k].is_branch         = info[k].is_branch;
            lane_packet[k].is_jalr           = info[k].is_jalr;
        end
    end

    for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_lane
        issue_lane_register u_lane (
            .clk      (clk),
            .reset    (reset),
            .flush_i  (flush_i),
            .load_i   (dispatch_ready_i[k]),
            .accept_i (accept[k]),
            .packet_i (lane_packet[k]),
            .valid_o  (dispatch_valid_o[k]),
            .packet_o (dispatch_o[k])
        );
    end

endmodule

// File: logic/phys_free_list.sv
module phys_free_list (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic [1:0]                                          pop_count_i,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0]                   push_valid_i,
    input  issue_pkg::phys_addr_t [issue_pkg::ISSUE_WIDTH-1:0]  push_phys_i,
    output issue_pkg::phys_addr_t [issue_pkg::ISSUE_WIDTH-1:0]  head_phys_o,
    output logic [issue_pkg::FREE_CNT_W-1:0]                    free_count_o
);

    import issue_pkg::*;

    phys_addr_t free_mem [FREE_DEPTH];

    logic [FREE_PTR_W-1:0] head_q;
    logic [FREE_PTR_W-1:0] tail_q;
    logic [FREE_CNT_W-1:0] count_q;

    logic [FREE_PTR_W-1:0] push_slot [ISSUE_WIDTH];
    logic [1:0]            push_total;

    // ====================
    // Tail slots for commits
    // ====================
    always_comb begin
        push_total = 2'd0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            push_slot[k] = tail_q + FREE_PTR_W'(push_total);   // Packed in lane order
            if (push_valid_i[k]) begin
                push_total = push_total + 2'd1;
            end
        end
    end

    // Next registers waiting at the head
    always_comb begin
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            head_phys_o[k] = free_mem[head_q + FREE_PTR_W'(k)];
        end
    end

    assign free_count_o = count_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= FREE_CNT_W'(FREE_DEPTH);     // Full after reset
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_mem[i] <= phys_addr_t'(PHYS_REGS - FREE_DEPTH + i);
            end
        end else begin
            head_q  <= head_q + FREE_PTR_W'(pop_count_i);
            tail_q  <= tail_q + FREE_PTR_W'(push_total);
            count_q <= count_q - FREE_CNT_W'(pop_count_i) + FREE_CNT_W'(push_total);
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (push_valid_i[k]) begin
                    free_mem[push_slot[k]] <= push_phys_i[k];
                end
            end
        end
    end

    // Rename must never take more than what is free
    assert property (@(posedge clk) disable iff (!reset)
        FREE_CNT_W'(pop_count_i) <= count_q)
        else $error("free list pop of %0d with only %0d free", pop_count_i, count_q);

    // Commits can only return registers that were handed out
    assert property (@(posedge clk) disable iff (!reset)
        (count_q - FREE_CNT_W'(pop_count_i) + FREE_CNT_W'(push_total))
            <= FREE_CNT_W'(FREE_DEPTH))
        else $error("free list overflow, %0d pushed onto %0d", push_total, count_q);

endmodule

// File: logic/rename_table.sv
module rename_table (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0]                     accept_i,
    input  issue_pkg::decode_info_t [issue_pkg::ISSUE_WIDTH-1:0]  info_i,
    input  issue_pkg::phys_addr_t [issue_pkg::ISSUE_WIDTH-1:0]    head_phys_i,
    output issue_pkg::phys_addr_t [issue_pkg::ISSUE_WIDTH-1:0]    rs1_phys_o,
    output issue_pkg::phys_addr_t [issue_pkg::ISSUE_WIDTH-1:0]    rs2_phys_o,
    output issue_pkg::phys_addr_t [issue_pkg::ISSUE_WIDTH-1:0]    rd_phys_o,
    output logic [1:0]                                            pop_count_o
);

    import issue_pkg::*;

    phys_addr_t rat_q [ARCH_REGS];

    logic [ISSUE_WIDTH-1:0] alloc;
    logic [1:0]             alloc_cnt;

    // ====================
    // Lookup, bypass, allocate
    // ====================
    always_comb begin
        alloc_cnt = 2'd0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            alloc[k] = accept_i[k] && info_i[k].writes_rd && (info_i[k].rd != '0);

            rs1_phys_o[k] = rat_q[info_i[k].rs1];
            rs2_phys_o[k] = rat_q[info_i[k].rs2];

            // Earlier lanes of this group override the table, the latest one wins
            for (int j = 0; j < ISSUE_WIDTH; j++) begin
                if (j < k && alloc[j] && info_i[j].rd == info_i[k].rs1) begin
                    rs1_phys_o[k] = rd_phys_o[j];
                end
                if (j < k && alloc[j] && info_i[j].rd == info_i[k].rs2) begin
                    rs2_phys_o[k] = rd_phys_o[j];
                end
            end

            if (info_i[k].rs1 == '0) rs1_phys_o[k] = '0;    // x0 is hardwired
            if (info_i[k].rs2 == '0) rs2_phys_o[k] = '0;

            if (alloc[k]) begin
                rd_phys_o[k] = head_phys_i[alloc_cnt];    // Skip heads used by earlier lanes
                alloc_cnt    = alloc_cnt + 2'd1;
            end else begin
                rd_phys_o[k] = '0;
            end
        end
    end

    assign pop_count_o = alloc_cnt;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat_q[i] <= phys_addr_t'(i);    // Identity map
            end
        end else begin
            // Lane order makes the last writer of an arch reg stick
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                if (alloc[k]) begin
                    rat_q[info_i[k].rd] <= rd_phys_o[k];
                end
            end
        end
    end

endmodule

// File: logic/rv32i_field_decoder.sv
module rv32i_field_decoder (
    input  logic [issue_pkg::XLEN-1:0] instruction_i,
    output issue_pkg::decode_info_t    info_o
);

    import issue_pkg::*;

    logic [6:0] opcode;

    assign opcode = instruction_i[6:0];

    always_comb begin
        info_o = '0;

        // Register fields sit at fixed positions in every format
        info_o.rd  = instruction_i[11:7];
        info_o.rs1 = instruction_i[19:15];
        info_o.rs2 = instruction_i[24:20];

        case (opcode)
            OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM: begin
                info_o.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                info_o.writes_rd = 1'b1;    // Link register
                info_o.is_branch = 1'b1;
            end
            OPC_JALR: begin
                info_o.writes_rd = 1'b1;
                info_o.is_branch = 1'b1;
                info_o.is_jalr   = 1'b1;
            end
            OPC_BRANCH: begin
                info_o.is_branch = 1'b1;
            end
            OPC_LOAD: begin
                info_o.writes_rd = 1'b1;
                info_o.is_mem    = 1'b1;
            end
            OPC_STORE: begin
                info_o.is_mem = 1'b1;       // No destination
            end
            default: begin
            end
        endcase
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module issue_stage_tb \
    -o issue_stage_sim \
    && ./obj_dir/issue_stage_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

// File: sources.f
+incdir+testbench
logic/issue_pkg.sv
logic/rv32i_field_decoder.sv
logic/phys_free_list.sv
logic/rename_table.sv
logic/issue_slot_arbiter.sv
logic/issue_lane_register.sv
logic/issue_stage.sv
testbench/issue_stage_tb.sv

// File: testbench/issue_stage_checks.svh
`ifndef ISSUE_STAGE_CHECKS_SVH
`define ISSUE_STAGE_CHECKS_SVH

// ====================
// Grants and valids
// ====================
assert property (@(posedge clk) disable iff (!reset) decode_ready == exp_ready)
    else begin
        errors = errors + 1;
        $display("** Error at %0t: decode_ready_o expected %b, got %b",
                 $time, $sampled(exp_ready), $sampled(decode_ready));
    end

assert property (@(posedge clk) disable iff (!reset) dispatch_valid == exp_valid)
    else begin
        errors = errors + 1;
        $display("** Error at %0t: dispatch_valid_o expected %b, got %b",
                 $time, $sampled(exp_valid), $sampled(dispatch_valid));
    end

// Nothing granted or presented during a flush
assert property (@(posedge clk) disable iff (!reset)
    flush |-> (decode_ready == '0 && dispatch_valid == '0))
    else begin
        errors = errors + 1;
        $display("** Error at %0t: decode_ready_o/dispatch_valid_o expected 000/000, got %b/%b",
                 $time, $sampled(decode_ready), $sampled(dispatch_valid));
    end

assert property (@(posedge clk) disable iff (!reset) $fell(flush) |-> dispatch_valid == '0)
    else begin
        errors = errors + 1;
        $display("** Error at %0t: dispatch_valid_o expected 000 after flush, got %b",
                 $time, $sampled(dispatch_valid));
    end

// ====================
// Per-lane payload
// ====================
for (genvar k = 0; k < ISSUE_WIDTH; k++) begin : g_lane_checks
    assert property (@(posedge clk) disable iff (!reset) dispatch[k] == exp_packet[k])
        else begin
            errors = errors + 1;
            $display("** Error at %0t: dispatch_o[%0d] expected %h, got %h",
                     $time, k, $sampled(exp_packet[k]), $sampled(dispatch[k]));
        end

    assert property (@(posedge clk) disable iff (!reset) !dispatch_ready[k] |-> !decode_ready[k])
        else begin
            errors = errors + 1;
            $display("** Error at %0t: decode_ready_o[%0d] expected 0, got 1", $time, k);
        end

    // Back-pressure holds the payload and drops the valid
    assert property (@(posedge clk) disable iff (!reset)
        (!dispatch_ready[k] && !flush) |=> (!dispatch_valid[k] && $stable(dispatch[k])))
        else begin
            errors = errors + 1;
            $display("** Error at %0t: dispatch_o[%0d] expected held %h, got %h (valid %b)",
                     $time, k, $sampled(exp_packet[k]), $sampled(dispatch[k]),
                     $sampled(dispatch_valid[k]));
        end
end

`endif

// File: testbench/issue_stage_tb.sv
module issue_stage_tb;

    import issue_pkg::*;

    localparam int TRAFFIC_CYCLES = 200;
    localparam int DRAIN_LIMIT    = 64;

    logic                               clk;
    logic                               reset;
    logic [ISSUE_WIDTH-1:0]             fetch_valid;
    fetch_packet_t [ISSUE_WIDTH-1:0]    fetch;
    logic [ISSUE_WIDTH-1:0]             decode_ready;
    logic [ISSUE_WIDTH-1:0]             dispatch_ready;
    logic [ISSUE_WIDTH-1:0]             dispatch_valid;
    dispatch_packet_t [ISSUE_WIDTH-1:0] dispatch;
    logic                               flush;
    logic [ISSUE_WIDTH-1:0]             commit_valid;
    phys_addr_t [ISSUE_WIDTH-1:0]       commit_phys;

    // ====================
    // Reference model state
    // ====================
    phys_addr_t                         model_rat [ARCH_REGS];
    phys_addr_t                         free_q [$];
    phys_addr_t                         busy_q [$];     // Handed out, not yet committed
    logic [ISSUE_WIDTH-1:0]             exp_ready;
    logic [ISSUE_WIDTH-1:0]             exp_accept;
    logic [ISSUE_WIDTH-1:0]             exp_alloc;
    logic [ISSUE_WIDTH-1:0]             exp_valid_q;    // Lane valids after the last edge
    logic [ISSUE_WIDTH-1:0]             exp_valid;
    dispatch_packet_t [ISSUE_WIDTH-1:0] next_packet;    // What each lane loads at the edge
    dispatch_packet_t [ISSUE_WIDTH-1:0] exp_packet;
    int                                 alloc_total;
    int                                 errors;
    int                                 timeouts;
    int                                 wait_cycles;

    issue_stage u_issue_stage (
        .clk              (clk),
        .reset            (reset),
        .fetch_valid_i    (fetch_valid),
        .fetch_i          (fetch),
        .decode_ready_o   (decode_ready),
        .dispatch_ready_i (dispatch_ready),
        .dispatch_valid_o (dispatch_valid),
        .dispatch_o       (dispatch),
        .flush_i          (flush),
        .commit_valid_i   (commit_valid),
        .commit_phys_i    (commit_phys)
    );

    `include "issue_stage_checks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [6:0] pick_opcode();
        case ($urandom_range(8, 0))
            0: return OPC_LUI;
            1: return OPC_AUIPC;
            2: return OPC_JAL;
            3: return OPC_JALR;
            4: return OPC_BRANCH;
            5: return OPC_LOAD;
            6: return OPC_STORE;
            7: return OPC_OP_IMM;
            default: return OPC_OP;
        endcase
    endfunction

    // Mostly x0 to x7 so that lanes of one group collide often
    function automatic arch_addr_t random_reg();
        if ($urandom_range(3, 0) == 0) begin
            return arch_addr_t'($urandom_range(31, 0));
        end
        return arch_addr_t'($urandom_range(7, 0));
    endfunction

    function automatic decode_info_t decode_fields(logic [XLEN-1:0] instr);
        decode_info_t info;
        logic [6:0]   opc;
        opc            = instr[6:0];
        info           = '0;
        info.rd        = instr[11:7];
        info.rs1       = instr[19:15];
        info.rs2       = instr[24:20];
        info.writes_rd = opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
                                     OPC_OP, OPC_OP_IMM, OPC_LOAD};
        info.is_branch = opc inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
        info.is_jalr   = (opc == OPC_JALR);
        info.is_mem    = opc inside {OPC_LOAD, OPC_STORE};
        return info;
    endfunction

    task automatic drive_inputs(input bit drain, input bit allow_commit, input bit allow_flush);
        arch_addr_t rd;
        logic [6:0] opc;
        int         idx;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            opc = drain ? OPC_OP : pick_opcode();
            rd  = drain ? arch_addr_t'($urandom_range(7, 1)) : random_reg();
            fetch[k].instruction       = {7'($urandom), random_reg(), random_reg(),
                                          3'($urandom), rd, opc};
            fetch[k].pc                = $urandom;
            fetch[k].pc_at_prediction  = $urandom;
            fetch[k].immediate         = $urandom;
            fetch[k].branch_prediction = 1'($urandom);
            dispatch_ready[k]          = drain || ($urandom_range(3, 0) != 0);
        end
        fetch_valid  = drain ? '1 : 3'($urandom);
        flush        = allow_flush && ($urandom_range(15, 0) == 0);
        commit_valid = '0;
        commit_phys  = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (allow_commit && busy_q.size() > 0 && $urandom_range(1, 0) == 1) begin
                idx             = int'($urandom_range(busy_q.size() - 1, 0));
                commit_phys[k]  = busy_q[idx];
                commit_valid[k] = 1'b1;
                busy_q.delete(idx);
            end
        end
    endtask

    // Grants, renaming and lane payloads for the inputs now driven
    task automatic compute_expect();
        decode_info_t info;
        phys_addr_t   src1;
        phys_addr_t   src2;
        int           grants;
        grants      = 0;
        alloc_total = 0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            exp_ready[k] = !flush && dispatch_ready[k] && (grants < free_q.size());
            if (exp_ready[k]) begin
                grants++;
            end
        end
        exp_accept = fetch_valid & exp_ready;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            info         = decode_fields(fetch[k].instruction);
            exp_alloc[k] = exp_accept[k] && info.writes_rd && (info.rd != '0);
            src1         = model_rat[info.rs1];
            src2         = model_rat[info.rs2];
            for (int j = 0; j < k; j++) begin   // Newest earlier writer wins
                if (exp_alloc[j] && next_packet[j].rd_arch == info.rs1) begin
                    src1 = next_packet[j].rd_phys;
                end
                if (exp_alloc[j] && next_packet[j].rd_arch == info.rs2) begin
                    src2 = next_packet[j].rd_phys;
                end
            end
            next_packet[k].pc                = fetch[k].pc;
            next_packet[k].pc_at_prediction  = fetch[k].pc_at_prediction;
            next_packet[k].immediate         = fetch[k].immediate;
            next_packet[k].branch_prediction = fetch[k].branch_prediction;
            next_packet[k].rs1_phys          = (info.rs1 == '0) ? '0 : src1;
            next_packet[k].rs2_phys          = (info.rs2 == '0) ? '0 : src2;
            next_packet[k].rd_arch           = info.rd;
            next_packet[k].writes_rd         = info.writes_rd;
            next_packet[k].is_mem            = info.is_mem;
            next_packet[k].is_branch         = info.is_branch;
            next_packet[k].is_jalr           = info.is_jalr;
            if (exp_alloc[k]) begin
                next_packet[k].rd_phys = free_q[alloc_total];
                alloc_total++;
            end else begin
                next_packet[k].rd_phys = '0;
            end
        end
        exp_valid = exp_valid_q & ~{ISSUE_WIDTH{flush}};
    endtask

    // Model side of the rising edge that just passed
    task automatic apply_edge();
        if (flush) begin
            exp_valid_q = '0;
            exp_packet  = '0;
        end else begin
            for (int k = 0; k < ISSUE_WIDTH; k++) begin
                exp_valid_q[k] = exp_accept[k];
                if (dispatch_ready[k]) begin
                    exp_packet[k] = next_packet[k];
                end
            end
        end
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (exp_alloc[k]) begin
                model_rat[next_packet[k].rd_arch] = next_packet[k].rd_phys;
                busy_q.push_back(next_packet[k].rd_phys);
            end
        end
        repeat (alloc_total) void'(free_q.pop_front());
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            if (commit_valid[k]) begin
                free_q.push_back(commit_phys[k]);   // Lane order
            end
        end
    endtask

    task automatic next_cycle(input bit drain, input bit allow_commit, input bit allow_flush);
        @(negedge clk);
        apply_edge();
        drive_inputs(drain, allow_commit, allow_flush);
        compute_expect();
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        void'($urandom(69135));
        errors         = 0;
        timeouts       = 0;
        alloc_total    = 0;
        reset          = 1'b0;
        fetch_valid    = '0;
        fetch          = '0;
        dispatch_ready = '0;
        flush          = 1'b0;
        commit_valid   = '0;
        commit_phys    = '0;
        exp_ready      = '0;
        exp_accept     = '0;
        exp_alloc      = '0;
        exp_valid_q    = '0;
        exp_valid      = '0;
        next_packet    = '0;
        exp_packet     = '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_rat[i] = phys_addr_t'(i);
        end
        for (int i = 0; i < FREE_DEPTH; i++) begin
            free_q.push_back(phys_addr_t'(ARCH_REGS + i));
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        drive_inputs(1'b0, 1'b1, 1'b0);
        compute_expect();

        repeat (TRAFFIC_CYCLES) next_cycle(1'b0, 1'b1, 1'b1);

        // Withhold commits until every free register is taken
        wait_cycles = 0;
        do begin
            next_cycle(1'b1, 1'b0, 1'b0);
            #1;
            wait_cycles++;
        end while (decode_ready != '0 && wait_cycles < DRAIN_LIMIT);
        if (decode_ready != '0) begin
            $display("Timeout: decode_ready_o still %b after %0d cycles without commits",
                     decode_ready, wait_cycles);
            timeouts++;
        end
        repeat (4) next_cycle(1'b1, 1'b0, 1'b0);

        repeat (TRAFFIC_CYCLES) next_cycle(1'b0, 1'b1, 1'b0);     // Reuse of committed regs
        repeat (TRAFFIC_CYCLES) next_cycle(1'b0, 1'b1, 1'b1);
        @(posedge clk);
        #1;

        $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
